// File: rtl/md_long_div.sv
// ==========================================================
// Restoring long divider with its own subtractor, sign
// fix-up and RISC-V division-by-zero and overflow results
// ==========================================================
`timescale 1ns/1ps

module md_long_div #(
  parameter int unsigned DataWidth = md_pkg::DataWidthDefault
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 div_en_i,
  input  logic                 ready_i,
  input  md_pkg::md_op_e       operator_i,
  input  logic [1:0]           signed_mode_i,
  input  logic [DataWidth-1:0] op_a_i,
  input  logic [DataWidth-1:0] op_b_i,
  output logic [DataWidth-1:0] div_result_o,
  output logic                 div_valid_o
);

  import md_pkg::*;

  localparam int unsigned CntWidth = $clog2(DataWidth);

  md_div_state_e        state_q;
  md_div_state_e        state_d;
  logic [CntWidth-1:0]  cnt_q;
  logic [CntWidth-1:0]  cnt_d;
  logic [CntWidth-1:0]  cnt_dec;
  logic                 div_update;

  // Absolute dividend and divisor, quotient and partial remainder
  logic [DataWidth-1:0] num_q;
  logic [DataWidth-1:0] num_d;
  logic [DataWidth-1:0] den_q;
  logic [DataWidth-1:0] den_d;
  logic [DataWidth-1:0] quo_q;
  logic [DataWidth-1:0] quo_d;
  logic [DataWidth:0]   rem_q;
  logic [DataWidth:0]   rem_d;

  // Shared subtractor, two bits wider so the borrow shows up as the sign
  logic [DataWidth+1:0] sub_a;
  logic [DataWidth+1:0] sub_b;
  logic [DataWidth+1:0] diff;

  logic                 sign_a;
  logic                 sign_b;
  logic                 b_zero;
  logic                 is_ge;
  logic                 flip_sign;
  logic [DataWidth-1:0] next_rem;
  logic [DataWidth-1:0] next_quo;

  assign sign_a    = signed_mode_i[0] & op_a_i[DataWidth-1];
  assign sign_b    = signed_mode_i[1] & op_b_i[DataWidth-1];
  assign b_zero    = (op_b_i == '0);
  // Quotient sign from both operands, remainder follows the dividend
  assign flip_sign = (operator_i == MD_OP_DIV) ? (sign_a ^ sign_b) : sign_a;

  always_comb begin
    sub_a = '0;
    unique case (state_q)
      DIV_ABS_A: begin
        sub_b = {2'b00, op_a_i};
      end
      DIV_COMP, DIV_LAST: begin
        sub_a = {1'b0, rem_q};
        sub_b = {2'b00, den_q};
      end
      DIV_CHANGE_SIGN: begin
        sub_b = {2'b00, rem_q[DataWidth-1:0]};
      end
      default: begin
        sub_b = {2'b00, op_b_i};
      end
    endcase
  end

  assign diff = sub_a - sub_b;

  // Trial subtraction result and the new quotient bit
  assign is_ge    = ~diff[DataWidth+1];
  assign next_rem = is_ge ? diff[DataWidth-1:0] : rem_q[DataWidth-1:0];
  assign next_quo = quo_q | ({{(DataWidth-1){1'b0}}, is_ge} << cnt_q);
  assign cnt_dec  = cnt_q - 1'b1;

  always_comb begin
    state_d     = state_q;
    cnt_d       = cnt_dec;
    num_d       = num_q;
    den_d       = den_q;
    quo_d       = quo_q;
    rem_d       = rem_q;
    div_valid_o = 1'b0;
    unique case (state_q)
      DIV_IDLE: begin
        // Preload the divide-by-zero answer
        if (operator_i == MD_OP_DIV) begin
          rem_d = {1'b0, {DataWidth{1'b1}}};
        end else begin
          rem_d = {1'b0, op_a_i};
        end
        cnt_d   = CntWidth'(DataWidth - 1);
        state_d = b_zero ? DIV_FINISH : DIV_ABS_A;
      end
      DIV_ABS_A: begin
        num_d   = sign_a ? diff[DataWidth-1:0] : op_a_i;
        quo_d   = '0;
        cnt_d   = CntWidth'(DataWidth - 1);
        state_d = DIV_ABS_B;
      end
      DIV_ABS_B: begin
        den_d   = sign_b ? diff[DataWidth-1:0] : op_b_i;
        rem_d   = {{DataWidth{1'b0}}, num_q[DataWidth-1]};
        cnt_d   = CntWidth'(DataWidth - 1);
        state_d = DIV_COMP;
      end
      DIV_COMP: begin
        // Shift in the next dividend bit behind the trial remainder
        rem_d   = {next_rem, num_q[cnt_dec]};
        quo_d   = next_quo;
        state_d = (cnt_q == CntWidth'(1)) ? DIV_LAST : DIV_COMP;
      end
      DIV_LAST: begin
        if (operator_i == MD_OP_DIV) begin
          rem_d = {1'b0, next_quo};
        end else begin
          rem_d = {1'b0, next_rem};
        end
        state_d = DIV_CHANGE_SIGN;
      end
      DIV_CHANGE_SIGN: begin
        if (flip_sign) begin
          rem_d = {1'b0, diff[DataWidth-1:0]};
        end
        state_d = DIV_FINISH;
      end
      DIV_FINISH: begin
        div_valid_o = 1'b1;
        state_d     = DIV_IDLE;
      end
      default: begin
        state_d = DIV_IDLE;
      end
    endcase
  end

  // Stalled in FINISH without ready, everything holds
  assign div_update = div_en_i & ~((state_q == DIV_FINISH) & ~ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else if (div_update) begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (div_update) begin
      num_q <= num_d;
      den_q <= den_d;
      quo_q <= quo_d;
      rem_q <= rem_d;
    end
  end

  assign div_result_o = rem_q[DataWidth-1:0];

  a_div_state_legal : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q inside {DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST,
                    DIV_CHANGE_SIGN, DIV_FINISH}
  );

endmodule

// File: rtl/md_operand_split.sv
// ==========================================================
// Operand splitter for the parallel multiplier: forms the
// sign-extended half-word pairs of the four partial products
// ==========================================================
`timescale 1ns/1ps

module md_operand_split #(
  parameter int unsigned DataWidth = md_pkg::DataWidthDefault
) (
  input  logic [DataWidth-1:0]                              op_a_i,
  input  logic [DataWidth-1:0]                              op_b_i,
  input  logic [1:0]                                        signed_mode_i,
  output logic [md_pkg::NumPartial*(DataWidth/2+1)-1:0]     pp_a_o,
  output logic [md_pkg::NumPartial*(DataWidth/2+1)-1:0]     pp_b_o
);

  localparam int unsigned HalfWidth = DataWidth / 2;

  logic                 sign_a;
  logic                 sign_b;
  logic [HalfWidth:0]   a_lo;
  logic [HalfWidth:0]   a_hi;
  logic [HalfWidth:0]   b_lo;
  logic [HalfWidth:0]   b_hi;

  // Only a signed operand carries its top bit into the high half
  assign sign_a = signed_mode_i[0] & op_a_i[DataWidth-1];
  assign sign_b = signed_mode_i[1] & op_b_i[DataWidth-1];

  // Low halves are always treated as unsigned
  assign a_lo = {1'b0, op_a_i[HalfWidth-1:0]};
  assign b_lo = {1'b0, op_b_i[HalfWidth-1:0]};

  assign a_hi = {sign_a, op_a_i[DataWidth-1:HalfWidth]};
  assign b_hi = {sign_b, op_b_i[DataWidth-1:HalfWidth]};

  // Pair order from slot 0 upward: al*bl, al*bh, ah*bl, ah*bh
  assign pp_a_o = {a_hi, a_hi, a_lo, a_lo};
  assign pp_b_o = {b_hi, b_lo, b_hi, b_lo};

endmodule

// File: rtl/md_partial_mult.sv
// ==========================================================
// Registered signed multiplier for one half-word pair
// ==========================================================
`timescale 1ns/1ps

module md_partial_mult #(
  parameter int unsigned DataWidth = md_pkg::DataWidthDefault
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        en_i,
  input  logic signed [DataWidth/2:0] a_i,
  input  logic signed [DataWidth/2:0] b_i,
  output logic signed [DataWidth+1:0] product_o
);

  logic signed [DataWidth+1:0] product_d;

  // Both operands are (half+1) bits, so the product is exact in DataWidth+2 bits
  assign product_d = a_i * b_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      product_o <= '0;
    end else if (en_i) begin
      product_o <= product_d;
    end
  end

endmodule

// File: rtl/md_pkg.sv
// ==========================================================
// Shared types and constants for the multiply/divide unit:
// operation codes, FSM state encodings and width constants
// ==========================================================

package md_pkg;

  // Number of partial products from the half-word split
  localparam int unsigned NumPartial = 4;

  // Default operand width of the unit
  localparam int unsigned DataWidthDefault = 32;

  // Operation selected by the core
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Long-division sequence
  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_CHANGE_SIGN,
    DIV_FINISH
  } md_div_state_e;

  // Multiplier result handshake
  typedef enum logic {
    MULT_LOAD,
    MULT_DONE
  } md_mult_state_e;

endpackage

// File: rtl/md_product_sum.sv
// ==========================================================
// Partial product summer: weights and adds the four products,
// selects the low or high word and runs the valid/hold FSM
// ==========================================================
`timescale 1ns/1ps

module md_product_sum #(
  parameter int unsigned DataWidth = md_pkg::DataWidthDefault
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           mult_en_i,
  input  logic                                           ready_i,
  input  md_pkg::md_op_e                                 operator_i,
  input  logic [md_pkg::NumPartial*(DataWidth+2)-1:0]    products_i,
  output logic [DataWidth-1:0]                           mult_result_o,
  output logic                                           mult_valid_o
);

  import md_pkg::*;

  localparam int unsigned HalfWidth = DataWidth / 2;
  localparam int unsigned ProdWidth = DataWidth + 2;
  localparam int unsigned SumWidth  = 2 * DataWidth + 2;

  logic signed [SumWidth-1:0] sum;
  md_mult_state_e             state_q;
  md_mult_state_e             state_d;

  // al*bl sits at bit 0, the cross terms at half a word, ah*bh at a full word
  function automatic int unsigned weight(int unsigned idx);
    int unsigned shift;
    if (idx == 0) begin
      shift = 0;
    end else if (idx == NumPartial - 1) begin
      shift = DataWidth;
    end else begin
      shift = HalfWidth;
    end
    return shift;
  endfunction

  always_comb begin
    logic signed [ProdWidth-1:0] pp;
    logic signed [SumWidth-1:0]  pp_ext;
    sum = '0;
    for (int unsigned i = 0; i < NumPartial; i++) begin
      pp     = products_i[i*ProdWidth +: ProdWidth];
      // Signed assignment sign-extends to the sum width
      pp_ext = pp;
      sum    = sum + (pp_ext <<< weight(i));
    end
  end

  assign mult_result_o = (operator_i == MD_OP_MULL) ? sum[DataWidth-1:0] :
                                                      sum[2*DataWidth-1:DataWidth];

  // Products are ready one cycle after the first enabled cycle
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MULT_LOAD: begin
        if (mult_en_i) begin
          state_d = MULT_DONE;
        end
      end
      MULT_DONE: begin
        // Held operands keep the products stable while stalled
        if (ready_i) begin
          state_d = MULT_LOAD;
        end
      end
      default: begin
        state_d = MULT_LOAD;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MULT_LOAD;
    end else begin
      state_q <= state_d;
    end
  end

  assign mult_valid_o = (state_q == MULT_DONE);

  a_mult_state_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !$isunknown(state_q)
  );

endmodule

// File: rtl/md_unit.sv
// ==========================================================
// Multiply/divide unit top: parallel multiplier chain, long
// divider and the merged result/valid outputs
// ==========================================================
`timescale 1ns/1ps

module md_unit #(
  parameter int unsigned DataWidth = md_pkg::DataWidthDefault
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 mult_en_i,
  input  logic                 div_en_i,
  input  md_pkg::md_op_e       operator_i,
  input  logic [1:0]           signed_mode_i,
  input  logic [DataWidth-1:0] op_a_i,
  input  logic [DataWidth-1:0] op_b_i,
  input  logic                 ready_i,
  output logic [DataWidth-1:0] result_o,
  output logic                 valid_o
);

  import md_pkg::*;

  localparam int unsigned PairWidth = DataWidth / 2 + 1;
  localparam int unsigned ProdWidth = DataWidth + 2;

  logic [NumPartial*PairWidth-1:0] pp_a;
  logic [NumPartial*PairWidth-1:0] pp_b;
  logic [NumPartial*ProdWidth-1:0] products;
  logic [DataWidth-1:0]            mult_result;
  logic                            mult_valid;
  logic [DataWidth-1:0]            div_result;
  logic                            div_valid;

  md_operand_split #(
    .DataWidth(DataWidth)
  ) u_operand_split (
    .op_a_i,
    .op_b_i,
    .signed_mode_i,
    .pp_a_o (pp_a),
    .pp_b_o (pp_b)
  );

  for (genvar i = 0; i < NumPartial; i++) begin : gen_partial
    md_partial_mult #(
      .DataWidth(DataWidth)
    ) u_partial_mult (
      .clk_i,
      .rst_ni,
      .en_i      (mult_en_i),
      .a_i       (pp_a[i*PairWidth +: PairWidth]),
      .b_i       (pp_b[i*PairWidth +: PairWidth]),
      .product_o (products[i*ProdWidth +: ProdWidth])
    );
  end

  md_product_sum #(
    .DataWidth(DataWidth)
  ) u_product_sum (
    .clk_i,
    .rst_ni,
    .mult_en_i,
    .ready_i,
    .operator_i,
    .products_i    (products),
    .mult_result_o (mult_result),
    .mult_valid_o  (mult_valid)
  );

  md_long_div #(
    .DataWidth(DataWidth)
  ) u_long_div (
    .clk_i,
    .rst_ni,
    .div_en_i,
    .ready_i,
    .operator_i,
    .signed_mode_i,
    .op_a_i,
    .op_b_i,
    .div_result_o (div_result),
    .div_valid_o  (div_valid)
  );

  assign valid_o  = mult_valid | div_valid;
  assign result_o = div_en_i ? div_result : mult_result;

  a_en_exclusive : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(mult_en_i && div_en_i)
  );

  // Both FSMs rely on the source holding its request until acceptance
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ((mult_en_i || div_en_i) && !(valid_o && ready_i)) |=>
      ($stable(op_a_i) && $stable(op_b_i) && $stable(operator_i) && $stable(signed_mode_i))
  );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the multiply/divide unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_md_unit -f src.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_md_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: src.f
rtl/md_pkg.sv
rtl/md_operand_split.sv
rtl/md_partial_mult.sv
rtl/md_product_sum.sv
rtl/md_long_div.sv
rtl/md_unit.sv
tb/tb_clk_gen.sv
tb/tb_md_unit.sv

// File: tb/tb_clk_gen.sv
// ==========================================================
// Testbench clock and active-low reset generator
// ==========================================================
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 8,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
  end

  always #(PeriodNs / 2) clk_o = ~clk_o;

  // Release reset shortly after a rising edge
  initial begin
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

// File: tb/tb_md_unit.sv
// ==========================================================
// Table-driven testbench for the multiply/divide unit with a
// reference model, compare tasks, back-pressure and watchdog
// ==========================================================
`timescale 1ns/1ps

module tb_md_unit;

  import md_pkg::*;

  localparam int unsigned DW          = DataWidthDefault;
  localparam int unsigned NumDirected = 17;
  localparam int unsigned NumRows     = NumDirected + 8;
  localparam int unsigned DivLatency  = 36;
  localparam int unsigned DriveDelay  = 1;
  localparam logic [31:0] Seed        = 32'h5cf6_d9a9;

  logic          clk;
  logic          rst_n;
  logic          mult_en;
  logic          div_en;
  md_op_e        op_sel;
  logic [1:0]    signed_mode;
  logic [DW-1:0] op_a;
  logic [DW-1:0] op_b;
  logic          ready;
  logic [DW-1:0] result;
  logic          valid;

  // Stimulus and expected value table
  md_op_e        tbl_op    [NumRows];
  logic [1:0]    tbl_mode  [NumRows];
  logic [DW-1:0] tbl_a     [NumRows];
  logic [DW-1:0] tbl_b     [NumRows];
  int unsigned   tbl_stall [NumRows];
  logic [DW-1:0] tbl_exp   [NumRows];

  int unsigned n_rows;
  int unsigned errors;
  int unsigned tests_ok;
  int unsigned tests_bad;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;

  tb_clk_gen #(
    .PeriodNs    (8),
    .ResetCycles (16)
  ) u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  md_unit #(
    .DataWidth (DW)
  ) i_dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .mult_en_i     (mult_en),
    .div_en_i      (div_en),
    .operator_i    (op_sel),
    .signed_mode_i (signed_mode),
    .op_a_i        (op_a),
    .op_b_i        (op_b),
    .ready_i       (ready),
    .result_o      (result),
    .valid_o       (valid)
  );

  // RISC-V results from full-width products and truncating division
  function automatic logic [DW-1:0] ref_result(md_op_e op, logic [1:0] mode,
                                               logic [DW-1:0] a, logic [DW-1:0] b);
    logic          neg_a;
    logic          neg_b;
    logic [2*DW-1:0] wide_a;
    logic [2*DW-1:0] wide_b;
    logic [2*DW-1:0] prod;
    logic [DW-1:0] mag_a;
    logic [DW-1:0] mag_b;
    logic [DW-1:0] quo;
    logic [DW-1:0] rem;
    logic [DW-1:0] res;
    neg_a  = mode[0] & a[DW-1];
    neg_b  = mode[1] & b[DW-1];
    wide_a = {{DW{neg_a}}, a};
    wide_b = {{DW{neg_b}}, b};
    prod   = wide_a * wide_b;
    mag_a  = neg_a ? -a : a;
    mag_b  = neg_b ? -b : b;
    quo    = '0;
    rem    = '0;
    if (mag_b != '0) begin
      quo = mag_a / mag_b;
      rem = mag_a % mag_b;
    end
    case (op)
      MD_OP_MULL: res = prod[DW-1:0];
      MD_OP_MULH: res = prod[2*DW-1:DW];
      MD_OP_DIV:  res = (b == '0) ? '1 : ((neg_a ^ neg_b) ? -quo : quo);
      default:    res = (b == '0) ? a : (neg_a ? -rem : rem);
    endcase
    return res;
  endfunction

  function automatic int unsigned expected_latency(md_op_e op, logic [DW-1:0] b);
    int unsigned lat;
    if (op == MD_OP_MULL || op == MD_OP_MULH || b == '0) begin
      lat = 1;
    end else begin
      lat = DivLatency;
    end
    return lat;
  endfunction

  function automatic int unsigned max_stall();
    int unsigned m;
    m = 0;
    for (int i = 0; i < NumRows; i++) begin
      if (tbl_stall[i] > m) begin
        m = tbl_stall[i];
      end
    end
    return m;
  endfunction

  task automatic add_row(input md_op_e op, input logic [1:0] mode, input logic [DW-1:0] a,
                         input logic [DW-1:0] b, input int unsigned stall,
                         input logic [DW-1:0] exp);
    tbl_op[n_rows]    = op;
    tbl_mode[n_rows]  = mode;
    tbl_a[n_rows]     = a;
    tbl_b[n_rows]     = b;
    tbl_stall[n_rows] = stall;
    tbl_exp[n_rows]   = exp;
    n_rows++;
  endtask

  task automatic load_table();
    logic [31:0]   r;
    md_op_e        op;
    logic [1:0]    mode;
    logic [DW-1:0] a;
    logic [DW-1:0] b;
    // Low product word
    add_row(MD_OP_MULL, 2'b11, 32'hffff_fffd, 32'h0000_0007, 0, 32'hffff_ffeb);
    add_row(MD_OP_MULL, 2'b00, 32'h0001_0000, 32'h0001_0001, 2, 32'h0001_0000);
    // High product word in each sign mode
    add_row(MD_OP_MULH, 2'b11, 32'hffff_fffe, 32'hffff_fffd, 0, 32'h0000_0000);
    add_row(MD_OP_MULH, 2'b11, 32'h8000_0000, 32'h8000_0000, 3, 32'h4000_0000);
    add_row(MD_OP_MULH, 2'b00, 32'hffff_ffff, 32'hffff_ffff, 0, 32'hffff_fffe);
    add_row(MD_OP_MULH, 2'b01, 32'hffff_ffff, 32'h0000_0002, 1, 32'hffff_ffff);
    add_row(MD_OP_MULH, 2'b11, 32'h8000_0000, 32'h0000_0001, 0, 32'hffff_ffff);
    // Truncated quotient and remainder
    add_row(MD_OP_DIV,  2'b11, 32'hffff_fff9, 32'h0000_0002, 0, 32'hffff_fffd);
    add_row(MD_OP_REM,  2'b11, 32'hffff_fff9, 32'h0000_0002, 2, 32'hffff_ffff);
    add_row(MD_OP_DIV,  2'b00, 32'hffff_fff9, 32'h0000_0002, 0, 32'h7fff_fffc);
    add_row(MD_OP_REM,  2'b00, 32'hffff_fff9, 32'h0000_0002, 0, 32'h0000_0001);
    add_row(MD_OP_REM,  2'b11, 32'h0000_0007, 32'hffff_fffe, 0, 32'h0000_0001);
    // Zero divisor and signed overflow
    add_row(MD_OP_DIV,  2'b11, 32'h0000_0064, 32'h0000_0000, 0, 32'hffff_ffff);
    add_row(MD_OP_REM,  2'b11, 32'hffff_ff9c, 32'h0000_0000, 1, 32'hffff_ff9c);
    add_row(MD_OP_DIV,  2'b11, 32'h8000_0000, 32'hffff_ffff, 0, 32'h8000_0000);
    add_row(MD_OP_REM,  2'b11, 32'h8000_0000, 32'hffff_ffff, 4, 32'h0000_0000);
    add_row(MD_OP_DIV,  2'b00, 32'h8000_0000, 32'hffff_ffff, 0, 32'h0000_0000);
    // Random operands in the sign modes the core issues
    while (n_rows < NumRows) begin
      r  = $urandom;
      op = md_op_e'(r[1:0]);
      if (op == MD_OP_DIV || op == MD_OP_REM) begin
        mode = r[2] ? 2'b11 : 2'b00;
      end else begin
        mode = (r[3:2] == 2'b10) ? 2'b01 : r[3:2];
      end
      a = $urandom;
      b = $urandom;
      add_row(op, mode, a, b, $urandom % 4, ref_result(op, mode, a, b));
    end
  endtask

  task automatic check_result(input md_op_e op, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("Fail at time %0t: %s result %h, expected %h", $time, op.name(), act, exp);
    end
  endtask

  task automatic check_valid(input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Fail at time %0t: valid_o is %b, expected %b", $time, act, exp);
    end
  endtask

  task automatic run_row(input int unsigned idx);
    md_op_e        op;
    logic [DW-1:0] exp;
    int unsigned   lat;
    int unsigned   stall;
    int unsigned   errs_before;
    op          = tbl_op[idx];
    exp         = tbl_exp[idx];
    stall       = tbl_stall[idx];
    lat         = expected_latency(op, tbl_b[idx]);
    errs_before = errors;
    @(posedge clk);
    #DriveDelay;
    op_sel      = op;
    signed_mode = tbl_mode[idx];
    op_a        = tbl_a[idx];
    op_b        = tbl_b[idx];
    mult_en     = (op == MD_OP_MULL || op == MD_OP_MULH);
    div_en      = (op == MD_OP_DIV || op == MD_OP_REM);
    ready       = (stall == 0);
    // Valid must rise exactly at the expected cycle
    for (int unsigned n = 0; n <= lat; n++) begin
      @(negedge clk);
      check_valid(n == lat, valid);
    end
    check_result(op, exp, result);
    // Back-pressure keeps valid and the result steady
    for (int unsigned s = 0; s < stall; s++) begin
      @(posedge clk);
      @(negedge clk);
      check_valid(1'b1, valid);
      check_result(op, exp, result);
    end
    if (stall > 0) begin
      @(posedge clk);
      #DriveDelay;
      ready = 1'b1;
    end
    // Acceptance edge
    @(posedge clk);
    #DriveDelay;
    mult_en = 1'b0;
    div_en  = 1'b0;
    ready   = 1'b0;
    if (errors == errs_before) begin
      tests_ok++;
    end else begin
      tests_bad++;
    end
    $display("Test %0d %s mode %b a %h b %h stall %0d: %s", idx, op.name(), tbl_mode[idx],
             tbl_a[idx], tbl_b[idx], stall, (errors == errs_before) ? "ok" : "error");
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not complete within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    mult_en     = 1'b0;
    div_en      = 1'b0;
    op_sel      = MD_OP_MULL;
    signed_mode = 2'b00;
    op_a        = '0;
    op_b        = '0;
    ready       = 1'b0;
    n_rows      = 0;
    errors      = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    void'($urandom(Seed));
    load_table();
    cycle_limit = NumRows * (40 + max_stall()) + 100;
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_valid(1'b0, valid);
    for (int unsigned i = 0; i < NumRows; i++) begin
      run_row(i);
    end
    $display("%0d tests, %0d ok, %0d with errors, %0d failed checks",
             NumRows, tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
